// ==== decode_result_reg.sv ====
`timescale 1ns/10ps

module decode_result_reg
    import mips_decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_loaded,
    input  logic      count_clear,
    input  decode_t   decode,
    output decode_t   result,
    output ri_count_t ri_count
);
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result   <= '0;
            ri_count <= '0;
        end else begin
            if (instr_loaded) begin
                result <= decode;
            end
            // a clear wins over an increment in the same cycle.
            if (count_clear) begin
                ri_count <= '0;
            end else if (instr_loaded && decode.exception_ri && ri_count != '1) begin
                ri_count <= ri_count + 16'd1;
            end
        end
    end

    a_count_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
        !count_clear |=> ri_count >= $past(ri_count))
        else $error("reserved instruction count fell without a clear");

endmodule

// ==== main_decoder.sv ====
`timescale 1ns/10ps
`include "mips_decode_config.svh"

module main_decoder
    import mips_decode_pkg::*;
(
    input  word_t   instr,
    output decode_t decode
);
    op_t        opcode;
    func_t      func;
    creg_addr_t rs;
    creg_addr_t rt;
    creg_addr_t rd;
    decode_t    special;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign func   = instr[5:0];

    special_decoder u_special (
        .func    (func),
        .rs      (rs),
        .rt      (rt),
        .rd      (rd),
        .special (special)
    );

    function automatic decode_t imm_op(decoded_op_t dop, alu_func_t alufunc, logic zeroext);
        decode_t d;
        d = '0;
        d.op = dop;
        d.srcrega = rs;
        d.destreg = rt;
        d.ctl.alufunc = alufunc;
        d.ctl.alusrc = IMM;
        d.ctl.regwrite = 1'b1;
        d.ctl.zeroext = zeroext;
        return d;
    endfunction

    // two-register branches compare rs with rt, the rest test rs alone.
    function automatic decode_t branch_op(decoded_op_t dop, branch_type_t btype,
                                          logic two_reg, logic link);
        decode_t d;
        d = '0;
        d.op = dop;
        d.srcrega = rs;
        d.ctl.branch = 1'b1;
        d.ctl.branch_type = btype;
        d.ctl.branch1 = !two_reg;
        d.ctl.branch2 = two_reg;
        if (two_reg) begin
            d.srcregb = rt;
        end
        if (link) begin
            d.destreg = `LINK_REG;
            d.ctl.regwrite = 1'b1;
            d.ctl.is_link = 1'b1;
        end
        return d;
    endfunction

    function automatic decode_t mem_op(decoded_op_t dop, logic store);
        decode_t d;
        d = '0;
        d.op = dop;
        d.srcrega = rs;
        d.ctl.alusrc = IMM;
        if (store) begin
            d.srcregb = rt;
            d.ctl.memwrite = 1'b1;
        end else begin
            d.destreg = rt;
            d.ctl.regwrite = 1'b1;
            d.ctl.memtoreg = 1'b1;
        end
        return d;
    endfunction

    always_comb begin
        decode = '0;
        case (opcode)
            `OP_SPECIAL: decode = special;
            `OP_ADDI:    decode = imm_op(ADD, ALU_ADD, 1'b0);
            `OP_ADDIU:   decode = imm_op(ADDU, ALU_ADDU, 1'b0);
            `OP_SLTI:    decode = imm_op(SLT, ALU_SLT, 1'b0);
            `OP_SLTIU:   decode = imm_op(SLTU, ALU_SLTU, 1'b0);
            `OP_ANDI:    decode = imm_op(AND, ALU_AND, 1'b1);
            `OP_ORI:     decode = imm_op(OR, ALU_OR, 1'b1);
            `OP_XORI:    decode = imm_op(XOR, ALU_XOR, 1'b1);
            `OP_LUI: begin
                decode = imm_op(LUI, ALU_LUI, 1'b0);
                decode.srcrega = '0;
            end
            `OP_BEQ:     decode = branch_op(BEQ, T_BEQ, 1'b1, 1'b0);
            `OP_BNE:     decode = branch_op(BNE, T_BNE, 1'b1, 1'b0);
            `OP_BGTZ:    decode = branch_op(BGTZ, T_BGTZ, 1'b0, 1'b0);
            `OP_BLEZ:    decode = branch_op(BLEZ, T_BLEZ, 1'b0, 1'b0);
            `OP_REGIMM: begin
                case (rt)
                    `B_BGEZ:   decode = branch_op(BGEZ, T_BGEZ, 1'b0, 1'b0);
                    `B_BLTZ:   decode = branch_op(BLTZ, T_BLTZ, 1'b0, 1'b0);
                    `B_BGEZAL: decode = branch_op(BGEZAL, T_BGEZ, 1'b0, 1'b1);
                    `B_BLTZAL: decode = branch_op(BLTZAL, T_BLTZ, 1'b0, 1'b1);
                    default:   decode = reserved_decode();
                endcase
            end
            `OP_J: begin
                decode.op = J;
                decode.ctl.jump = 1'b1;
            end
            `OP_JAL: begin
                decode.op = JAL;
                decode.destreg = `LINK_REG;
                decode.ctl.jump = 1'b1;
                decode.ctl.regwrite = 1'b1;
                decode.ctl.is_link = 1'b1;
            end
            `OP_LB:      decode = mem_op(LB, 1'b0);
            `OP_LBU:     decode = mem_op(LBU, 1'b0);
            `OP_LH:      decode = mem_op(LH, 1'b0);
            `OP_LHU:     decode = mem_op(LHU, 1'b0);
            `OP_LW:      decode = mem_op(LW, 1'b0);
            `OP_SB:      decode = mem_op(SB, 1'b1);
            `OP_SH:      decode = mem_op(SH, 1'b1);
            `OP_SW:      decode = mem_op(SW, 1'b1);
            default:     decode = reserved_decode();
        endcase
    end

    // covers the SPECIAL rows as well, which come from the special decoder.
    a_dest_needs_write: assert final (decode.ctl.regwrite || decode.destreg == '0)
        else $error("destination register named without a register write");
    a_ri_matches_op: assert final (decode.exception_ri == (decode.op == RESERVED))
        else $error("reserved flag disagrees with the decoded op");

endmodule

// ==== mips_decode_config.svh ====
`ifndef MIPS_DECODE_CONFIG_SVH
`define MIPS_DECODE_CONFIG_SVH

// primary opcode field, instr[31:26].
`define OP_SPECIAL 6'b000000
`define OP_REGIMM  6'b000001
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_BLEZ    6'b000110
`define OP_BGTZ    6'b000111
`define OP_ADDI    6'b001000
`define OP_ADDIU   6'b001001
`define OP_SLTI    6'b001010
`define OP_SLTIU   6'b001011
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111
`define OP_LB      6'b100000
`define OP_LH      6'b100001
`define OP_LW      6'b100011
`define OP_LBU     6'b100100
`define OP_LHU     6'b100101
`define OP_SB      6'b101000
`define OP_SH      6'b101001
`define OP_SW      6'b101011

// SPECIAL function field, instr[5:0].
`define F_SLL      6'b000000
`define F_SRL      6'b000010
`define F_SRA      6'b000011
`define F_SLLV     6'b000100
`define F_SRLV     6'b000110
`define F_SRAV     6'b000111
`define F_JR       6'b001000
`define F_JALR     6'b001001
`define F_MOVZ     6'b001010
`define F_MOVN     6'b001011
`define F_SYSCALL  6'b001100
`define F_BREAK    6'b001101
`define F_SYNC     6'b001111
`define F_MFHI     6'b010000
`define F_MTHI     6'b010001
`define F_MFLO     6'b010010
`define F_MTLO     6'b010011
`define F_MULT     6'b011000
`define F_MULTU    6'b011001
`define F_DIV      6'b011010
`define F_DIVU     6'b011011
`define F_ADD      6'b100000
`define F_ADDU     6'b100001
`define F_SUB      6'b100010
`define F_SUBU     6'b100011
`define F_AND      6'b100100
`define F_OR       6'b100101
`define F_XOR      6'b100110
`define F_NOR      6'b100111
`define F_SLT      6'b101010
`define F_SLTU     6'b101011

// REGIMM rt field, instr[20:16].
`define B_BLTZ     5'b00000
`define B_BGEZ     5'b00001
`define B_BLTZAL   5'b10000
`define B_BGEZAL   5'b10001

`define LINK_REG   5'd31

// word addresses of the host register map.
`define ADDR_INSTR    2'd0
`define ADDR_DECODE   2'd1
`define ADDR_CTRL     2'd2
`define ADDR_RI_COUNT 2'd3

`endif

// ==== mips_decode_pkg.sv ====
package mips_decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;
    typedef logic [5:0]  op_t;
    typedef logic [5:0]  func_t;
    typedef logic [1:0]  wb_addr_t;
    typedef logic [15:0] ri_count_t;

    // SLL sits at zero so that an all-zero result reads back as a NOP.
    typedef enum logic [5:0] {
        SLL, SRL, SRA, SLLV, SRLV, SRAV,
        ADD, ADDU, SUB, SUBU, SLT, SLTU,
        AND, OR, XOR, NOR, LUI, MOVZ, MOVN,
        JR, JALR, MFHI, MFLO, MTHI, MTLO,
        MULT, MULTU, DIV, DIVU, BREAK, SYSCALL,
        BEQ, BNE, BGTZ, BLEZ, BGEZ, BLTZ, BGEZAL, BLTZAL,
        J, JAL,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        RESERVED = 6'd63
    } decoded_op_t;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_LUI,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_PASSA, ALU_PASSB, ALU_MOVZ, ALU_MOVN
    } alu_func_t;

    typedef enum logic {
        REGB,
        IMM
    } alu_src_t;

    typedef enum logic [2:0] {
        T_BEQ, T_BNE, T_BGEZ, T_BLTZ, T_BGTZ, T_BLEZ
    } branch_type_t;

    // bit 26 is spare and always reads as zero.
    typedef struct packed {
        logic         spare;
        alu_func_t    alufunc;
        alu_src_t     alusrc;
        branch_type_t branch_type;
        logic         regwrite;
        logic         memtoreg;
        logic         memwrite;
        logic         hiwrite;
        logic         lowrite;
        logic         hitoreg;
        logic         lotoreg;
        logic         branch;
        logic         branch1;
        logic         branch2;
        logic         jump;
        logic         jr;
        logic         is_link;
        logic         zeroext;
        logic         shamt_valid;
        logic         is_bp;
        logic         is_sys;
    } control_t;

    typedef struct packed {
        decoded_op_t op;
        logic        exception_ri;
        creg_addr_t  srcrega;
        creg_addr_t  srcregb;
        creg_addr_t  destreg;
        control_t    ctl;
    } decode_t;

    // result for any code outside the kept instruction set.
    function automatic decode_t reserved_decode();
        decode_t d;
        d = '0;
        d.op = RESERVED;
        d.exception_ri = 1'b1;
        d.ctl.alufunc = ALU_PASSA;
        return d;
    endfunction

endpackage

// ==== mips_decode_top.f ====
+incdir+.
mips_decode_pkg.sv
special_decoder.sv
main_decoder.sv
wb_instr_port.sv
decode_result_reg.sv
mips_decode_top.sv
tb_mips_decode_top.sv

// ==== mips_decode_top.sv ====
`timescale 1ns/10ps

module mips_decode_top
    import mips_decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  word_t    wb_dat_w,
    output word_t    wb_dat_r,
    output logic     wb_ack
);
    word_t     instr;
    logic      instr_loaded;
    logic      count_clear;
    decode_t   decode;
    decode_t   result;
    ri_count_t ri_count;

    wb_instr_port u_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .result       (result),
        .ri_count     (ri_count),
        .wb_ack       (wb_ack),
        .wb_dat_r     (wb_dat_r),
        .instr        (instr),
        .instr_loaded (instr_loaded),
        .count_clear  (count_clear)
    );

    main_decoder u_decoder (
        .instr  (instr),
        .decode (decode)
    );

    decode_result_reg u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_loaded (instr_loaded),
        .count_clear  (count_clear),
        .decode       (decode),
        .result       (result),
        .ri_count     (ri_count)
    );

endmodule

// ==== special_decoder.sv ====
`timescale 1ns/10ps
`include "mips_decode_config.svh"

module special_decoder
    import mips_decode_pkg::*;
(
    input  func_t      func,
    input  creg_addr_t rs,
    input  creg_addr_t rt,
    input  creg_addr_t rd,
    output decode_t    special
);
    // register to register ALU op; shifts by shamt leave source A at zero.
    function automatic decode_t alu_rr(decoded_op_t dop, alu_func_t alufunc,
                                       logic shift_imm);
        decode_t d;
        d = '0;
        d.op = dop;
        d.srcrega = shift_imm ? 5'd0 : rs;
        d.srcregb = rt;
        d.destreg = rd;
        d.ctl.alufunc = alufunc;
        d.ctl.regwrite = 1'b1;
        d.ctl.shamt_valid = shift_imm;
        return d;
    endfunction

    always_comb begin
        special = '0;
        case (func)
            `F_ADD:  special = alu_rr(ADD, ALU_ADD, 1'b0);
            `F_ADDU: special = alu_rr(ADDU, ALU_ADDU, 1'b0);
            `F_SUB:  special = alu_rr(SUB, ALU_SUB, 1'b0);
            `F_SUBU: special = alu_rr(SUBU, ALU_SUBU, 1'b0);
            `F_SLT:  special = alu_rr(SLT, ALU_SLT, 1'b0);
            `F_SLTU: special = alu_rr(SLTU, ALU_SLTU, 1'b0);
            `F_AND:  special = alu_rr(AND, ALU_AND, 1'b0);
            `F_OR:   special = alu_rr(OR, ALU_OR, 1'b0);
            `F_XOR:  special = alu_rr(XOR, ALU_XOR, 1'b0);
            `F_NOR:  special = alu_rr(NOR, ALU_NOR, 1'b0);
            `F_SLLV: special = alu_rr(SLLV, ALU_SLL, 1'b0);
            `F_SRLV: special = alu_rr(SRLV, ALU_SRL, 1'b0);
            `F_SRAV: special = alu_rr(SRAV, ALU_SRA, 1'b0);
            `F_SLL:  special = alu_rr(SLL, ALU_SLL, 1'b1);
            `F_SRL:  special = alu_rr(SRL, ALU_SRL, 1'b1);
            `F_SRA:  special = alu_rr(SRA, ALU_SRA, 1'b1);
            `F_MOVZ: special = alu_rr(MOVZ, ALU_MOVZ, 1'b0);
            `F_MOVN: special = alu_rr(MOVN, ALU_MOVN, 1'b0);
            `F_JR, `F_JALR: begin
                special.op = JR;
                special.srcrega = rs;
                special.ctl.alufunc = ALU_PASSA;
                special.ctl.jump = 1'b1;
                special.ctl.jr = 1'b1;
                if (func == `F_JALR) begin
                    special.op = JALR;
                    special.destreg = `LINK_REG;
                    special.ctl.regwrite = 1'b1;
                    special.ctl.is_link = 1'b1;
                end
            end
            `F_MFHI: begin
                special.op = MFHI;
                special.destreg = rd;
                special.ctl.regwrite = 1'b1;
                special.ctl.alufunc = ALU_PASSA;
                special.ctl.hitoreg = 1'b1;
            end
            `F_MFLO: begin
                special.op = MFLO;
                special.destreg = rd;
                special.ctl.regwrite = 1'b1;
                special.ctl.alufunc = ALU_PASSB;
                special.ctl.lotoreg = 1'b1;
            end
            `F_MTHI, `F_MTLO: begin
                special.op = (func == `F_MTHI) ? MTHI : MTLO;
                special.srcrega = rs;
                special.ctl.alufunc = ALU_PASSA;
                special.ctl.hiwrite = (func == `F_MTHI);
                special.ctl.lowrite = (func == `F_MTLO);
            end
            `F_MULT, `F_MULTU, `F_DIV, `F_DIVU: begin
                special.srcrega = rs;
                special.srcregb = rt;
                special.ctl.hiwrite = 1'b1;
                special.ctl.lowrite = 1'b1;
                case (func)
                    `F_MULT:  special.op = MULT;
                    `F_MULTU: special.op = MULTU;
                    `F_DIV:   special.op = DIV;
                    default:  special.op = DIVU;
                endcase
            end
            `F_BREAK: begin
                special.op = BREAK;
                special.ctl.alufunc = ALU_PASSA;
                special.ctl.is_bp = 1'b1;
            end
            `F_SYSCALL: begin
                special.op = SYSCALL;
                special.ctl.alufunc = ALU_PASSA;
                special.ctl.is_sys = 1'b1;
            end
            // SYNC has no effect here, so it decodes as a NOP.
            `F_SYNC: special = '0;
            default: special = reserved_decode();
        endcase
    end

endmodule

// ==== tb_decode_input.txt ====
// instruction(hex) op srcrega srcregb destreg exception_ri (decimal) control(hex)
// a trailing word names the instruction and is not read.
20431234 6 2 0 3 0 0110000 ADDI
2d090020 11 8 0 9 0 0b10000 SLTIU
314b00ff 12 10 0 11 0 0d10008 ANDI
3c10abcd 16 0 0 16 0 1510000 LUI
00221820 6 1 2 3 0 0010000 ADD
00e84827 15 7 8 9 0 1210000 NOR
00032143 2 0 3 4 0 1a10004 SRA
00c53804 3 6 5 7 0 1610000 SLLV
0022180b 18 1 2 3 0 2210000 MOVN
03e00008 19 31 0 0 0 1c00060 JR
0120f809 20 9 0 31 0 1c10070 JALR
00002810 21 0 0 5 0 1c10800 MFHI
00c00013 24 6 0 0 0 1c01000 MTLO
00220019 26 1 2 0 0 0003000 MULTU
0064001a 27 3 4 0 0 0003000 DIV
0000000c 30 0 0 0 0 1c00001 SYSCALL
0000000f 0 0 0 0 0 0000000 SYNC
10220004 31 1 2 0 0 0000280 BEQ
1ca00010 33 5 0 0 0 0080300 BGTZ
04e10003 35 7 0 0 0 0040300 BGEZ
05500005 38 10 0 31 0 0070310 BLTZAL
08100040 39 0 0 0 0 0000040 J
0c100040 40 0 0 31 0 0010050 JAL
90640001 42 3 0 4 0 0118000 LBU
8fbf0010 45 29 0 31 0 0118000 LW
a4640002 47 3 4 0 0 0104000 SH
afbf0018 48 29 31 0 0 0104000 SW
70221802 63 0 0 0 1 1c00000 MUL
40026000 63 0 0 0 1 1c00000 MFC0
42000018 63 0 0 0 1 1c00000 ERET
bc200000 63 0 0 0 1 1c00000 CACHE
c0220000 63 0 0 0 1 1c00000 LL
e0220000 63 0 0 0 1 1c00000 SC
88220000 63 0 0 0 1 1c00000 LWL
98220000 63 0 0 0 1 1c00000 LWR
a8220000 63 0 0 0 1 1c00000 SWL
b8220000 63 0 0 0 1 1c00000 SWR

// ==== tb_wb_master.svh ====
`ifndef TB_WB_MASTER_SVH
`define TB_WB_MASTER_SVH

// Wishbone classic master. Signals change 5 ns after a rising edge and ack is
// sampled at that same point, well away from the edge.

task automatic wb_write(input wb_addr_t adr, input word_t data);
    int waited;
    @(posedge clk);
    #5;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b1;
    wb_adr = adr;
    wb_dat_w = data;
    waited = 0;
    do begin
        @(posedge clk);
        #5;
        waited++;
    end while (!wb_ack && waited < 20);
    if (!wb_ack) begin
        $display("no ack from the DUT within 20 cycles on a write to address %0d", adr);
        err_count++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
endtask

task automatic wb_read(input wb_addr_t adr, output word_t data);
    int waited;
    @(posedge clk);
    #5;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b0;
    wb_adr = adr;
    waited = 0;
    data = '0;
    do begin
        @(posedge clk);
        #5;
        waited++;
    end while (!wb_ack && waited < 20);
    if (wb_ack) begin
        data = wb_dat_r;
    end else begin
        $display("no ack from the DUT within 20 cycles on a read from address %0d", adr);
        err_count++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
endtask

// linear congruential generator, one step per call.
function automatic word_t lcg_next(input word_t state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// ==== tb_mips_decode_top.sv ====
`timescale 1ns/10ps
`include "mips_decode_config.svh"

module tb_mips_decode_top
    import mips_decode_pkg::*;
();
    logic     clk;
    logic     rst_n;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    word_t    wb_dat_w;
    word_t    wb_dat_r;
    logic     wb_ack;
    int       err_count;
    int       test_start_errs;
    int       tests_ok;
    int       tests_bad;
    word_t    lcg_state;

    `include "tb_wb_master.svh"

    mips_decode_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always begin
        #50 clk = ~clk;
    end

    task automatic check_op(input decoded_op_t got, input decoded_op_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_reg(input creg_addr_t got, input creg_addr_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_ctl(input control_t got, input control_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_count(input ri_count_t got, input ri_count_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic close_test(input string name);
        if (err_count == test_start_errs) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: %0d errors", name, err_count - test_start_errs);
            tests_bad++;
        end
        test_start_errs = err_count;
    endtask

    // kept encodings of the instruction set; everything else is reserved.
    function automatic logic reserved_word(input word_t w);
        logic r;
        r = 1'b1;
        case (w[31:26])
            6'h00: begin
                case (w[5:0])
                    6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0a,
                    6'h0b, 6'h0c, 6'h0d, 6'h0f, 6'h10, 6'h11, 6'h12, 6'h13, 6'h18,
                    6'h19, 6'h1a, 6'h1b, 6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25,
                    6'h26, 6'h27, 6'h2a, 6'h2b: r = 1'b0;
                    default: r = 1'b1;
                endcase
            end
            6'h01: begin
                case (w[20:16])
                    5'h00, 5'h01, 5'h10, 5'h11: r = 1'b0;
                    default: r = 1'b1;
                endcase
            end
            6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0a, 6'h0b,
            6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28,
            6'h29, 6'h2b: r = 1'b0;
            default: r = 1'b1;
        endcase
        return r;
    endfunction

    initial begin
        integer             fd;
        reg [8*128-1:0]     text_line;
        word_t              w;
        word_t              rd_word;
        word_t              e_ctl;
        int                 e_op;
        int                 e_rs;
        int                 e_rt;
        int                 e_rd;
        int                 e_ri;
        int                 n;
        int                 ri_total;
        int                 ri_pred;
        clk = 1'b0;
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        err_count = 0;
        test_start_errs = 0;
        tests_ok = 0;
        tests_bad = 0;
        ri_total = 0;
        ri_pred = 0;
        lcg_state = 32'h9344;
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;

        wb_read(`ADDR_INSTR, rd_word);
        check_word(rd_word, '0, "instruction after reset");
        wb_read(`ADDR_DECODE, rd_word);
        check_word(rd_word, '0, "decode after reset");
        wb_read(`ADDR_RI_COUNT, rd_word);
        check_count(rd_word[15:0], '0, "count after reset");
        close_test("reset values");

        fd = $fopen("tb_decode_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tb_decode_input.txt for reading");
            err_count++;
            close_test("decode table");
        end else begin
            while ($fgets(text_line, fd) != 0) begin
                n = $sscanf(text_line, "%h %d %d %d %d %d %h",
                            w, e_op, e_rs, e_rt, e_rd, e_ri, e_ctl);
                // comment and blank lines do not parse into seven fields.
                if (n == 7) begin
                    wb_write(`ADDR_INSTR, w);
                    wb_read(`ADDR_INSTR, rd_word);
                    check_word(rd_word, w, "instruction readback");
                    wb_read(`ADDR_DECODE, rd_word);
                    check_op(decoded_op_t'(rd_word[21:16]), decoded_op_t'(e_op), "op");
                    check_flag(rd_word[15], e_ri[0], "exception_ri");
                    check_reg(rd_word[14:10], e_rs[4:0], "srcrega");
                    check_reg(rd_word[9:5], e_rt[4:0], "srcregb");
                    check_reg(rd_word[4:0], e_rd[4:0], "destreg");
                    wb_read(`ADDR_CTRL, rd_word);
                    check_ctl(control_t'(rd_word[26:0]), control_t'(e_ctl[26:0]), "ctl");
                    ri_total += e_ri;
                    close_test($sformatf("decode %h", w));
                end
            end
            $fclose(fd);
        end

        wb_read(`ADDR_RI_COUNT, rd_word);
        check_count(rd_word[15:0], ri_total[15:0], "count after the table");
        wb_write(`ADDR_RI_COUNT, 32'h0000_1234);
        wb_read(`ADDR_RI_COUNT, rd_word);
        check_count(rd_word[15:0], '0, "count after a clear");
        // ADDI with rs r2 and rt r3 decodes as op ADD, srcrega r2 and destreg r3.
        wb_write(`ADDR_INSTR, 32'h2043_1234);
        wb_write(`ADDR_DECODE, 32'hffff_ffff);
        wb_read(`ADDR_DECODE, rd_word);
        check_word(rd_word, {10'd0, 6'd6, 1'b0, 5'd2, 5'd0, 5'd3},
                   "decode after a write to it");
        close_test("count clear and decode write");

        repeat (20) begin
            lcg_state = lcg_next(lcg_state);
            wb_write(`ADDR_INSTR, lcg_state);
            if (reserved_word(lcg_state)) begin
                ri_pred++;
            end
        end
        wb_read(`ADDR_RI_COUNT, rd_word);
        check_count(rd_word[15:0], ri_pred[15:0], "count after random words");
        close_test("random reserved count");

        $display("%0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== wb_instr_port.sv ====
`timescale 1ns/10ps
`include "mips_decode_config.svh"

module wb_instr_port
    import mips_decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  wb_addr_t  wb_adr,
    input  word_t     wb_dat_w,
    input  decode_t   result,
    input  ri_count_t ri_count,
    output logic      wb_ack,
    output word_t     wb_dat_r,
    output word_t     instr,
    output logic      instr_loaded,
    output logic      count_clear
);
    logic  req;
    logic  wr_instr;
    logic  wr_count;
    word_t rd_data;

    // a cycle already being acknowledged does not count as a new request.
    assign req      = wb_cyc && wb_stb && !wb_ack;
    assign wr_instr = req && wb_we && (wb_adr == `ADDR_INSTR);
    assign wr_count = req && wb_we && (wb_adr == `ADDR_RI_COUNT);

    always_comb begin
        case (wb_adr)
            `ADDR_INSTR:  rd_data = instr;
            `ADDR_DECODE: rd_data = {10'd0, result.op, result.exception_ri,
                                     result.srcrega, result.srcregb, result.destreg};
            `ADDR_CTRL:   rd_data = {5'd0, result.ctl};
            default:      rd_data = {16'd0, ri_count};
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack       <= 1'b0;
            instr_loaded <= 1'b0;
            count_clear  <= 1'b0;
            instr        <= '0;
        end else begin
            wb_ack       <= req;
            instr_loaded <= wr_instr;
            count_clear  <= wr_count;
            if (wr_instr) begin
                instr <= wb_dat_w;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule
